/* run.sh */
#!/usr/bin/env bash
# build and run the fat32 reader testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_top -Mdir "$BUILD" -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

# keep running past the first assertion error so the summary is printed
"./$BUILD/sim_tb" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

/* src/dir_scanner.sv */
`timescale 1ns/10ps

module dir_scanner (
	input  logic                    iCLK,
	input  logic                    iRSTn,
	input  logic                    volume_ready,
	input  fat32_pkg::sector_addr_t rootdir_addr,
	input  logic                    read_done,
	input  fat32_pkg::byte_t        buf_data,
	output logic                    scan_start,
	output fat32_pkg::sector_addr_t scan_addr,
	output fat32_pkg::buf_addr_t    scan_buf_addr,
	output logic                    catalog_ready,
	output reader_pkg::file_index_t file_count,
	input  reader_pkg::file_index_t cat_index,
	output fat32_pkg::cluster_t     cat_cluster,
	output fat32_pkg::file_size_t   cat_size
);

	reader_pkg::scan_state_t                              state;
	logic [$clog2(reader_pkg::ROOT_SCAN_SECTORS)-1:0]      sec_idx;
	logic [$clog2(fat32_pkg::DIR_ENTRIES_PER_SECTOR)-1:0] ent_idx;
	logic [$clog2(fat32_pkg::DIR_ENTRY_BYTES):0]          bcnt;
	logic [255:0]                                         entry_q;
	logic [255:0]                                         ent;  // byte 0 at the top
	fat32_pkg::byte_t                                     d0, d1, d2, d3;
	logic [9:0]                                           file_num;
	logic                                                 name_ok, is_bin, is_end;
	logic                                                 entry_done, cat_we;
	fat32_pkg::cluster_t                                  ent_cluster;
	fat32_pkg::file_size_t                                ent_size;
	logic [55:0]                                          cat_mem [reader_pkg::CATALOG_DEPTH];

	function automatic fat32_pkg::byte_t ent_byte(input logic [255:0] e, input int k);
		return e[255 - 8 * k -: 8];
	endfunction

	function automatic logic is_digit(input fat32_pkg::byte_t b);
		return (b >= 8'h30) && (b <= 8'h39);
	endfunction

	assign ent           = {entry_q[247:0], buf_data};
	assign scan_buf_addr = 9'(int'(ent_idx) * fat32_pkg::DIR_ENTRY_BYTES) + 9'(bcnt[4:0]);
	assign entry_done    = (state == reader_pkg::S_ENTRY) &&
	                       (int'(bcnt) == fat32_pkg::DIR_ENTRY_BYTES);
	assign catalog_ready = (state == reader_pkg::S_DONE);

	////////////////////
	// entry decode

	always_comb
	begin
		d0 = ent_byte(ent, 0);
		d1 = ent_byte(ent, 1);
		d2 = ent_byte(ent, 2);
		d3 = ent_byte(ent, 3);
		if (!is_digit(d1))
			file_num = 10'(d0[3:0]);
		else if (!is_digit(d2))
			file_num = 10'(d0[3:0]) * 10'd10 + 10'(d1[3:0]);
		else
			file_num = 10'(d0[3:0]) * 10'd100 + 10'(d1[3:0]) * 10'd10 + 10'(d2[3:0]);
		name_ok = is_digit(d0) && !(is_digit(d1) && is_digit(d2) && is_digit(d3));
		is_bin = {ent_byte(ent, fat32_pkg::ENT_EXT_OFS), ent_byte(ent, fat32_pkg::ENT_EXT_OFS + 1),
		          ent_byte(ent, fat32_pkg::ENT_EXT_OFS + 2)} == "BIN";
		is_end = (d0 == fat32_pkg::DIR_END);
		ent_cluster = {ent_byte(ent, fat32_pkg::ENT_CLUS_HI_OFS),
		               ent_byte(ent, fat32_pkg::ENT_CLUS_LO_OFS + 1),
		               ent_byte(ent, fat32_pkg::ENT_CLUS_LO_OFS)};
		ent_size = {ent_byte(ent, fat32_pkg::ENT_SIZE_OFS + 3), ent_byte(ent, fat32_pkg::ENT_SIZE_OFS + 2),
		            ent_byte(ent, fat32_pkg::ENT_SIZE_OFS + 1), ent_byte(ent, fat32_pkg::ENT_SIZE_OFS)};
		cat_we = entry_done && !is_end && (d0 != fat32_pkg::DIR_DELETED) && name_ok && is_bin &&
		         (int'(file_num) < reader_pkg::CATALOG_DEPTH);
	end

	always_ff @(posedge iCLK)
		entry_q <= ent;

	// catalog ram, lookup answers one cycle later
	always_ff @(posedge iCLK)
	begin
		if (cat_we)
			cat_mem[file_num[7:0]] <= {ent_cluster, ent_size};
		{cat_cluster, cat_size} <= cat_mem[cat_index];
	end

	always_ff @(posedge iCLK)
	begin
		if (iRSTn)
		begin
			state      <= reader_pkg::S_IDLE;
			scan_start <= 1'b0;
			file_count <= '0;
			sec_idx    <= '0;
			ent_idx    <= '0;
			bcnt       <= '0;
		end
		else
		begin
			scan_start <= 1'b0;
			case (state)
				reader_pkg::S_IDLE:
					if (volume_ready)
						state <= reader_pkg::S_READ;
				reader_pkg::S_READ:
				begin
					scan_start <= 1'b1;
					scan_addr  <= rootdir_addr + 32'(sec_idx);
					state      <= reader_pkg::S_WAIT;
				end
				reader_pkg::S_WAIT:
					if (read_done)
					begin
						ent_idx <= '0;
						bcnt    <= '0;
						state   <= reader_pkg::S_ENTRY;
					end
				reader_pkg::S_ENTRY:
					if (!entry_done)
						bcnt <= bcnt + 1'b1;
					else
					begin
						bcnt <= '0;
						if (cat_we)
							file_count <= file_count + 1'b1;
						if (is_end)
							state <= reader_pkg::S_DONE;
						else if (int'(ent_idx) == fat32_pkg::DIR_ENTRIES_PER_SECTOR - 1)
						begin
							sec_idx <= sec_idx + 1'b1;
							if (int'(sec_idx) == reader_pkg::ROOT_SCAN_SECTORS - 1)
								state <= reader_pkg::S_DONE;  // scan bound reached
							else
								state <= reader_pkg::S_READ;
						end
						else
							ent_idx <= ent_idx + 1'b1;
					end
				default: ;
			endcase
		end
	end

endmodule

/* src/fat32_pkg.sv */
package fat32_pkg;

	////////////////////
	// widths with a meaning on disk

	typedef logic [7:0]  byte_t;         // one byte of sector data
	typedef logic [8:0]  buf_addr_t;     // offset inside a 512-byte sector
	typedef logic [31:0] sector_addr_t;  // card lba
	typedef logic [23:0] cluster_t;
	typedef logic [31:0] file_size_t;    // bytes

	////////////////////
	// mbr and boot sector

	// jump instruction at the head of a boot sector
	localparam byte_t JUMP_B0 = 8'hEB;
	localparam byte_t JUMP_B1 = 8'h58;
	localparam byte_t JUMP_B2 = 8'h90;

	localparam buf_addr_t MBR_PART_LBA_OFS = 9'h1C6;  // start lba of partition 0
	localparam buf_addr_t DBR_SPC_OFS      = 9'h00D;  // sectors per cluster
	localparam buf_addr_t DBR_RSVD_OFS     = 9'h00E;  // two-byte reserved count
	localparam buf_addr_t DBR_SPF_OFS      = 9'h024;  // four-byte sectors per fat

	////////////////////
	// directory entries

	localparam int DIR_ENTRY_BYTES        = 32;
	localparam int DIR_ENTRIES_PER_SECTOR = 16;

	localparam byte_t DIR_DELETED = 8'hE5;
	localparam byte_t DIR_END     = 8'h00;  // no entries follow

	localparam cluster_t FIRST_DATA_CLUSTER = 24'd2;

	// byte offsets inside one entry
	localparam int ENT_EXT_OFS     = 8;
	localparam int ENT_CLUS_HI_OFS = 20;
	localparam int ENT_CLUS_LO_OFS = 26;
	localparam int ENT_SIZE_OFS    = 28;

endpackage

/* src/fat32_reader.sv */
`timescale 1ns/10ps

module fat32_reader (
	input  logic                    iCLK,
	input  logic                    iRSTn,
	input  logic                    init_done,
	input  logic                    byte_available,
	input  fat32_pkg::buf_addr_t    addr_i,
	input  fat32_pkg::byte_t        data_i,
	input  logic                    read_done,
	output logic                    sector_rd_start,
	output fat32_pkg::sector_addr_t sector_rd_addr,
	input  logic                    file_en,
	input  reader_pkg::file_index_t file_sel,
	output logic                    reader_idle,
	output reader_pkg::file_index_t file_count,
	output logic                    file_reading,
	output fat32_pkg::file_size_t   file_size,
	output fat32_pkg::file_size_t   file_read_size,
	output logic                    multi_sector_en
);

	reader_pkg::owner_t      owner;
	fat32_pkg::byte_t        buf_data;
	logic                    loc_start, scan_start, str_start;
	fat32_pkg::sector_addr_t loc_addr, scan_addr, str_addr;
	fat32_pkg::buf_addr_t    loc_buf_addr, scan_buf_addr;
	logic [2:0]              spc_shift;
	fat32_pkg::sector_addr_t rootdir_addr;
	logic                    volume_ready, catalog_ready;
	reader_pkg::file_index_t cat_index;
	fat32_pkg::cluster_t     cat_cluster;
	fat32_pkg::file_size_t   cat_size;

	// stages take the card strictly in turn
	assign owner = !volume_ready  ? reader_pkg::LOCATE :
	               !catalog_ready ? reader_pkg::SCAN : reader_pkg::STREAM;

	sector_buffer u_buf (
		.iCLK, .iRSTn, .byte_available, .addr_i, .data_i, .owner,
		.loc_start, .loc_addr, .loc_buf_addr,
		.scan_start, .scan_addr, .scan_buf_addr,
		.str_start, .str_addr,
		.buf_data, .sector_rd_start, .sector_rd_addr
	);

	volume_locator u_locate (
		.iCLK, .iRSTn, .init_done, .read_done, .buf_data,
		.loc_start, .loc_addr, .loc_buf_addr,
		.spc_shift, .rootdir_addr, .volume_ready
	);

	dir_scanner u_scan (
		.iCLK, .iRSTn, .volume_ready, .rootdir_addr, .read_done, .buf_data,
		.scan_start, .scan_addr, .scan_buf_addr,
		.catalog_ready, .file_count, .cat_index, .cat_cluster, .cat_size
	);

	file_streamer u_stream (
		.iCLK, .iRSTn, .catalog_ready, .file_en, .file_sel,
		.cat_index, .cat_cluster, .cat_size, .spc_shift, .rootdir_addr, .byte_available,
		.str_start, .str_addr, .multi_sector_en, .reader_idle, .file_reading,
		.file_size, .file_read_size
	);

endmodule

/* src/file_streamer.sv */
`timescale 1ns/10ps

module file_streamer (
	input  logic                    iCLK,
	input  logic                    iRSTn,
	input  logic                    catalog_ready,
	input  logic                    file_en,
	input  reader_pkg::file_index_t file_sel,
	output reader_pkg::file_index_t cat_index,
	input  fat32_pkg::cluster_t     cat_cluster,
	input  fat32_pkg::file_size_t   cat_size,
	input  logic [2:0]              spc_shift,
	input  fat32_pkg::sector_addr_t rootdir_addr,
	input  logic                    byte_available,
	output logic                    str_start,
	output fat32_pkg::sector_addr_t str_addr,
	output logic                    multi_sector_en,
	output logic                    reader_idle,
	output logic                    file_reading,
	output fat32_pkg::file_size_t   file_size,
	output fat32_pkg::file_size_t   file_read_size
);

	reader_pkg::stream_state_t state;
	fat32_pkg::sector_addr_t   first_sector;

	// cluster 2 sits at the root directory
	assign first_sector = rootdir_addr +
	                      (32'(cat_cluster - fat32_pkg::FIRST_DATA_CLUSTER) << spc_shift);

	assign file_reading = (state == reader_pkg::F_STREAM);

	always_ff @(posedge iCLK)
	begin
		if (iRSTn)
		begin
			state           <= reader_pkg::F_WAIT;
			str_start       <= 1'b0;
			multi_sector_en <= 1'b0;
			reader_idle     <= 1'b0;
			file_size       <= '0;
			file_read_size  <= '0;
		end
		else
		begin
			str_start <= 1'b0;
			case (state)
				reader_pkg::F_WAIT:
					if (catalog_ready)
					begin
						reader_idle <= 1'b1;
						state       <= reader_pkg::F_IDLE;
					end
				reader_pkg::F_IDLE:
					if (file_en)
					begin
						cat_index      <= file_sel;
						file_read_size <= '0;
						reader_idle    <= 1'b0;
						state          <= reader_pkg::F_LOOKUP;
					end
				reader_pkg::F_LOOKUP:
					state <= reader_pkg::F_START;  // catalog read latency
				reader_pkg::F_START:
				begin
					str_start       <= 1'b1;
					str_addr        <= first_sector;
					file_size       <= cat_size;
					multi_sector_en <= 1'b1;  // card streams while this is high
					state           <= reader_pkg::F_STREAM;
				end
				reader_pkg::F_STREAM:
					if (file_read_size == file_size)
					begin
						multi_sector_en <= 1'b0;
						reader_idle     <= 1'b1;
						state           <= reader_pkg::F_IDLE;  // card keeps sending, bytes dropped
					end
					else if (byte_available)
						file_read_size <= file_read_size + 1'b1;
				default:
				begin
					multi_sector_en <= 1'b0;
					reader_idle     <= 1'b0;
					state           <= reader_pkg::F_WAIT;
				end
			endcase
		end
	end

endmodule

/* src/reader_pkg.sv */
package reader_pkg;

	typedef logic [7:0] file_index_t;  // catalog slot is the file number

	localparam int CATALOG_DEPTH     = 256;
	localparam int ROOT_SCAN_SECTORS = 4;  // bound on the root directory walk

	// stage that drives the card port
	typedef enum logic [1:0] {LOCATE, SCAN, STREAM} owner_t;

	////////////////////
	// stage state machines

	typedef enum logic [2:0] {
		L_IDLE, L_WAIT_MBR, L_SIG, L_PART,
		L_WAIT_DBR, L_BPB, L_SPF, L_DONE
	} locate_state_t;

	typedef enum logic [2:0] {
		S_IDLE, S_READ, S_WAIT, S_ENTRY, S_DONE
	} scan_state_t;

	typedef enum logic [2:0] {
		F_WAIT, F_IDLE, F_LOOKUP, F_START, F_STREAM
	} stream_state_t;

endpackage

/* src/sector_buffer.sv */
`timescale 1ns/10ps

module sector_buffer (
	input  logic                    iCLK,
	input  logic                    iRSTn,
	input  logic                    byte_available,
	input  fat32_pkg::buf_addr_t    addr_i,
	input  fat32_pkg::byte_t        data_i,
	input  reader_pkg::owner_t      owner,
	input  logic                    loc_start,
	input  fat32_pkg::sector_addr_t loc_addr,
	input  fat32_pkg::buf_addr_t    loc_buf_addr,
	input  logic                    scan_start,
	input  fat32_pkg::sector_addr_t scan_addr,
	input  fat32_pkg::buf_addr_t    scan_buf_addr,
	input  logic                    str_start,
	input  fat32_pkg::sector_addr_t str_addr,
	output fat32_pkg::byte_t        buf_data,
	output logic                    sector_rd_start,
	output fat32_pkg::sector_addr_t sector_rd_addr
);

	fat32_pkg::byte_t        mem [0:511];
	fat32_pkg::buf_addr_t    rd_addr;
	logic                    req_start;
	fat32_pkg::sector_addr_t req_addr;

	// requester select
	always_comb
	begin
		case (owner)
			reader_pkg::LOCATE:
			begin
				req_start = loc_start;
				req_addr  = loc_addr;
				rd_addr   = loc_buf_addr;
			end
			reader_pkg::SCAN:
			begin
				req_start = scan_start;
				req_addr  = scan_addr;
				rd_addr   = scan_buf_addr;
			end
			default:
			begin
				req_start = str_start;
				req_addr  = str_addr;
				rd_addr   = '0;  // streamed data bypasses the buffer
			end
		endcase
	end

	// card writes win over reads
	always_ff @(posedge iCLK)
	begin
		if (byte_available)
			mem[addr_i] <= data_i;
		else
			buf_data <= mem[rd_addr];
	end

	////////////////////
	// card request port

	always_ff @(posedge iCLK)
	begin
		if (iRSTn)
		begin
			sector_rd_start <= 1'b0;
			sector_rd_addr  <= '0;
		end
		else
		begin
			sector_rd_start <= req_start;
			if (req_start)
				sector_rd_addr <= req_addr;  // held until the next start
		end
	end

endmodule

/* src/volume_locator.sv */
`timescale 1ns/10ps

module volume_locator (
	input  logic                    iCLK,
	input  logic                    iRSTn,
	input  logic                    init_done,
	input  logic                    read_done,
	input  fat32_pkg::byte_t        buf_data,
	output logic                    loc_start,
	output fat32_pkg::sector_addr_t loc_addr,
	output fat32_pkg::buf_addr_t    loc_buf_addr,
	output logic [2:0]              spc_shift,
	output fat32_pkg::sector_addr_t rootdir_addr,
	output logic                    volume_ready
);

	reader_pkg::locate_state_t state;
	logic [2:0]                idx;           // byte step inside a field run
	logic [31:0]               shreg;         // bytes enter at the top
	logic [31:0]               le_word;       // little endian word ending at buf_data
	logic [15:0]               rsvd_sectors;

	function automatic logic [2:0] spc_to_shift(input fat32_pkg::byte_t spc);
		case (spc)
			8'd8:    return 3'd3;
			8'd16:   return 3'd4;
			8'd32:   return 3'd5;
			default: return 3'd6;  // treat as 64
		endcase
	endfunction

	assign le_word      = {buf_data, shreg[31:8]};
	assign volume_ready = (state == reader_pkg::L_DONE);

	// buffer byte wanted in each state, data comes back one cycle later
	always_comb
	begin
		case (state)
			reader_pkg::L_SIG:  loc_buf_addr = fat32_pkg::buf_addr_t'(idx);
			reader_pkg::L_PART: loc_buf_addr = fat32_pkg::MBR_PART_LBA_OFS + 9'(idx);
			reader_pkg::L_BPB:  loc_buf_addr = (idx == 3'd0) ? fat32_pkg::DBR_SPC_OFS :
			                                   fat32_pkg::DBR_RSVD_OFS + 9'(idx - 3'd1);
			reader_pkg::L_SPF:  loc_buf_addr = fat32_pkg::DBR_SPF_OFS + 9'(idx);
			default:            loc_buf_addr = '0;
		endcase
	end

	always_ff @(posedge iCLK)
		shreg <= le_word;

	always_ff @(posedge iCLK)
	begin
		if (iRSTn)
		begin
			state     <= reader_pkg::L_IDLE;
			loc_start <= 1'b0;
			idx       <= '0;
			spc_shift <= '0;
		end
		else
		begin
			loc_start <= 1'b0;
			idx       <= idx + 1'b1;
			case (state)
				reader_pkg::L_IDLE:
					if (init_done)
					begin
						loc_start <= 1'b1;
						loc_addr  <= '0;  // sector 0 first
						state     <= reader_pkg::L_WAIT_MBR;
					end
				reader_pkg::L_WAIT_MBR:
				begin
					idx <= '0;
					if (read_done)
						state <= reader_pkg::L_SIG;
				end
				reader_pkg::L_SIG:
					if (idx == 3'd3)
					begin
						if (buf_data == fat32_pkg::JUMP_B2 && shreg[31:24] == fat32_pkg::JUMP_B1 &&
						    shreg[23:16] == fat32_pkg::JUMP_B0)
						begin
							loc_start <= 1'b1;  // sector 0 is already the dbr
							loc_addr  <= '0;
							state     <= reader_pkg::L_WAIT_DBR;
						end
						else
						begin
							idx   <= '0;
							state <= reader_pkg::L_PART;
						end
					end
				reader_pkg::L_PART:
					if (idx == 3'd4)
					begin
						loc_start <= 1'b1;
						loc_addr  <= le_word;  // partition start is the dbr
						state     <= reader_pkg::L_WAIT_DBR;
					end
				reader_pkg::L_WAIT_DBR:
				begin
					idx <= '0;
					if (read_done)
						state <= reader_pkg::L_BPB;
				end
				reader_pkg::L_BPB:
					if (idx == 3'd3)
					begin
						spc_shift    <= spc_to_shift(shreg[23:16]);
						rsvd_sectors <= {buf_data, shreg[31:24]};
						idx          <= '0;
						state        <= reader_pkg::L_SPF;
					end
				reader_pkg::L_SPF:
					if (idx == 3'd4)
					begin
						// root follows both fat copies
						rootdir_addr <= loc_addr + 32'(rsvd_sectors) + {le_word[30:0], 1'b0};
						state        <= reader_pkg::L_DONE;
					end
				default: ;
			endcase
		end
	end

endmodule

/* tb.f */
src/fat32_pkg.sv
src/reader_pkg.sv
src/sector_buffer.sv
src/volume_locator.sv
src/dir_scanner.sv
src/file_streamer.sv
src/fat32_reader.sv
testbench/fat32_props.sv
testbench/tb_clock.sv
testbench/tb_top.sv

/* testbench/fat32_props.sv */
`timescale 1ns/10ps

module fat32_props (
	input logic iCLK,
	input logic iRSTn,
	input logic init_done,
	input logic sector_rd_start,
	input logic file_reading,
	input logic multi_sector_en,
	input logic reader_idle
);

	int violations = 0;  // failed property count

	// card port stays quiet until the card is initialized
	quiet_before_init: assert property (@(posedge iCLK) disable iff (iRSTn)
		!init_done |-> !sector_rd_start && !file_reading && !multi_sector_en)
	else
	begin
		$error("card port active before init_done");
		violations++;
	end

	start_one_cycle: assert property (@(posedge iCLK) disable iff (iRSTn)
		sector_rd_start |=> !sector_rd_start)
	else
	begin
		$error("sector_rd_start held for two cycles");
		violations++;
	end

	reading_is_multi: assert property (@(posedge iCLK) disable iff (iRSTn)
		file_reading |-> multi_sector_en)
	else
	begin
		$error("file_reading without multi_sector_en");
		violations++;
	end

	idle_not_reading: assert property (@(posedge iCLK) disable iff (iRSTn)
		!(reader_idle && file_reading))
	else
	begin
		$error("reader_idle and file_reading both high");
		violations++;
	end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
	output logic iCLK,
	output logic iRSTn
);

	localparam int RESET_CYCLES = 8;

	initial
	begin
		iCLK = 1'b0;
		forever #4 iCLK = ~iCLK;  // 8 ns period
	end

	// reset high for the first cycles, dropped on a falling edge
	initial
	begin
		iRSTn = 1'b1;
		repeat (RESET_CYCLES) @(posedge iCLK);
		@(negedge iCLK);
		iRSTn = 1'b0;
	end

endmodule

/* testbench/tb_top.sv */
`timescale 1ns/10ps

module tb_top;

	localparam logic [31:0] SEED     = 32'hfb0e_a09b;
	localparam int          TIMEOUT  = 20000;  // cycles allowed per wait
	localparam logic [31:0] DBR_LBA  = 32'h20;
	localparam int          RSVD     = 4;
	localparam int          SPF      = 3;      // sectors per fat
	localparam int          SPC      = 8;      // sectors per cluster
	localparam logic [31:0] ROOT_LBA = DBR_LBA + RSVD + 2 * SPF;  // behind both fats

	logic        iCLK, iRSTn;
	logic        init_done, file_en;
	logic [7:0]  file_sel;
	logic        byte_available = 1'b0;
	logic        read_done      = 1'b0;
	logic [8:0]  addr_i         = '0;
	logic [7:0]  data_i         = '0;
	logic        sector_rd_start, reader_idle, file_reading, multi_sector_en;
	logic [31:0] sector_rd_addr, file_size, file_read_size;
	logic [7:0]  file_count;

	// card model
	logic        card_busy    = 1'b0;
	logic        card_multi   = 1'b0;
	logic        done_pending = 1'b0;
	logic [31:0] card_lba     = '0;
	int          card_pos     = 0;
	int          stream_bytes = 0;
	logic [31:0] start_log [$];

	int          errors, tests_run, tests_failed, test_err0;
	int          exp_num  [3] = '{1, 7, 12};
	int unsigned exp_clus [3] = '{3, 5, 32'h1_0004};
	int unsigned exp_size [3] = '{700, 100, 530};

	tb_clock u_clk (.iCLK(iCLK), .iRSTn(iRSTn));

	fat32_reader u_dut (
		.iCLK, .iRSTn, .init_done, .byte_available, .addr_i, .data_i, .read_done,
		.sector_rd_start, .sector_rd_addr, .file_en, .file_sel, .reader_idle,
		.file_count, .file_reading, .file_size, .file_read_size, .multi_sector_en
	);

	bind fat32_reader fat32_props u_props (
		.iCLK(iCLK), .iRSTn(iRSTn), .init_done(init_done),
		.sector_rd_start(sector_rd_start), .file_reading(file_reading),
		.multi_sector_en(multi_sector_en), .reader_idle(reader_idle)
	);

	////////////////////
	// disk image

	function automatic logic [7:0] entry_byte(input string name, input string ext,
		input logic [31:0] clus, input logic [31:0] size, input int k);
		if (k < 8)
			return (k < name.len()) ? name[k] : 8'h20;  // space padded
		if (k < 11)
			return ext[k - 8];
		case (k)
			20: return clus[23:16];
			21: return clus[31:24];
			26: return clus[7:0];
			27: return clus[15:8];
			28: return size[7:0];
			29: return size[15:8];
			30: return size[23:16];
			31: return size[31:24];
			default: return 8'h00;
		endcase
	endfunction

	function automatic logic [7:0] dir_byte(input int ofs);
		int k;
		k = ofs % 32;
		case (ofs / 32)
			0: return entry_byte($sformatf("%0d", exp_num[0]), "BIN", exp_clus[0], exp_size[0], k);
			1: return (k == 0) ? 8'hE5 : entry_byte("5", "BIN", 32'd9, 32'd50, k);  // deleted
			2: return entry_byte($sformatf("%0d", exp_num[1]), "BIN", exp_clus[1], exp_size[1], k);
			3: return entry_byte("42", "TXT", 32'd7, 32'd64, k);
			4: return entry_byte($sformatf("%0d", exp_num[2]), "BIN", exp_clus[2], exp_size[2], k);
			default: return 8'h00;  // end of directory
		endcase
	endfunction

	function automatic logic [7:0] image_byte(input logic [31:0] lba, input logic [8:0] ofs);
		if (lba == 32'h0)
			case (ofs)
				9'h000: return 8'hFA;  // boot code, no jump
				9'h1C2: return 8'h0C;
				9'h1C6: return DBR_LBA[7:0];
				9'h1C7: return DBR_LBA[15:8];
				9'h1C8: return DBR_LBA[23:16];
				9'h1C9: return DBR_LBA[31:24];
				9'h1FE: return 8'h55;
				9'h1FF: return 8'hAA;
				default: return 8'h00;
			endcase
		if (lba == DBR_LBA)
			case (ofs)
				9'h000: return 8'hEB;
				9'h001: return 8'h58;
				9'h002: return 8'h90;
				9'h00C: return 8'h02;  // 512 bytes per sector
				9'h00D: return 8'(SPC);
				9'h00E: return 8'(RSVD);
				9'h010: return 8'h02;  // two fats
				9'h024: return 8'(SPF);
				9'h1FE: return 8'h55;
				9'h1FF: return 8'hAA;
				default: return 8'h00;
			endcase
		if (lba == ROOT_LBA)
			return dir_byte(int'(ofs));
		return lba[7:0] ^ lba[15:8] ^ lba[23:16] ^ lba[31:24] ^ ofs[7:0] ^ {7'd0, ofs[8]};
	endfunction

	////////////////////
	// sd card model

	always @(negedge iCLK)
	begin
		byte_available = 1'b0;
		read_done      = 1'b0;
		if (iRSTn)
		begin
			card_busy    = 1'b0;
			done_pending = 1'b0;
		end
		else if (done_pending)
		begin
			read_done    = 1'b1;
			done_pending = 1'b0;
		end
		else if (card_busy)
		begin
			if (card_multi && !multi_sector_en)
				card_busy = 1'b0;  // reader stopped taking bytes
			else
			begin
				byte_available = 1'b1;
				addr_i         = 9'(card_pos);
				data_i         = image_byte(card_lba, 9'(card_pos));
				if (card_multi)
					stream_bytes++;
				if (card_pos == 511)
				begin
					card_pos = 0;
					card_lba++;
					if (!card_multi)
					begin
						card_busy    = 1'b0;
						done_pending = 1'b1;
					end
				end
				else
					card_pos++;
			end
		end
		else if (sector_rd_start)
		begin
			card_busy  = 1'b1;
			card_multi = multi_sector_en;
			card_lba   = sector_rd_addr;
			card_pos   = 0;
			start_log.push_back(sector_rd_addr);
			if (multi_sector_en)
				stream_bytes = 0;
		end
	end

	////////////////////
	// check and wait helpers

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic abort_run(input string what);
		$display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
		$display("FAIL: see errors above");
		$fatal(1, "run aborted");
	endtask

	task automatic start_test();
		test_err0 = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_err0)
		begin
			tests_failed++;
			$display("test %s: failed", name);
		end
		else
			$display("test %s: ok", name);
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while ((iRSTn || n == 0) && n < TIMEOUT)
		begin
			@(negedge iCLK);
			n++;
		end
		if (iRSTn)
			abort_run("reset release");
	endtask

	task automatic wait_reader_idle();
		int n;
		n = 0;
		while (!reader_idle && n < TIMEOUT)
		begin
			@(negedge iCLK);
			n++;
		end
		if (!reader_idle)
			abort_run("reader_idle rise");
	endtask

	task automatic stream_file(input int i);
		int          n;
		logic [31:0] exp_start;
		start_test();
		exp_start = ROOT_LBA + (exp_clus[i] - 2) * SPC;
		file_sel  = 8'(exp_num[i]);
		file_en   = 1'b1;
		n = 0;
		do
		begin
			@(negedge iCLK);
			file_en = 1'b0;
			n++;
		end
		while (!file_reading && n < TIMEOUT);
		if (!file_reading)
			abort_run("file_reading rise");
		check_value("file_reading delay", n, 3);  // accept edge plus 2 cycles
		check_value("file_size", file_size, exp_size[i]);
		n = 0;
		while (file_reading && n < TIMEOUT)
		begin
			@(negedge iCLK);
			n++;
		end
		if (file_reading)
			abort_run("file_reading fall");
		check_value("reader_idle", 32'(reader_idle), 1);
		check_value("file_read_size", file_read_size, exp_size[i]);
		check_value("sector_rd_addr", sector_rd_addr, exp_start);
		@(negedge iCLK);
		// one spare byte goes out while the size compare settles
		check_value("byte_available count", stream_bytes, exp_size[i] + 1);
		end_test($sformatf("file %0d", exp_num[i]));
	endtask

	////////////////////
	// stimulus

	initial
	begin
		int order [3];
		int j;
		int tmp;
		void'($urandom(SEED));
		init_done    = 1'b0;
		file_en      = 1'b0;
		file_sel     = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		wait_reset_release();

		start_test();
		repeat (20)
		begin
			@(negedge iCLK);
			check_value("sector_rd_start", 32'(sector_rd_start), 0);
			check_value("file_reading", 32'(file_reading), 0);
			check_value("multi_sector_en", 32'(multi_sector_en), 0);
		end
		end_test("quiet before init");

		init_done = 1'b1;
		wait_reader_idle();

		start_test();
		check_value("file_count", 32'(file_count), 3);  // deleted and txt skipped
		end_test("catalog count");

		start_test();
		check_value("sector read count", start_log.size(), 3);
		if (start_log.size() >= 3)
		begin
			check_value("sector_rd_addr mbr", start_log[0], 32'h0);
			check_value("sector_rd_addr dbr", start_log[1], DBR_LBA);
			check_value("sector_rd_addr root", start_log[2], ROOT_LBA);
		end
		end_test("volume addresses");

		for (int i = 0; i < 3; i++)
			order[i] = i;
		for (int i = 2; i > 0; i--)
		begin
			j        = int'($urandom % 32'(i + 1));
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < 3; i++)
			stream_file(order[i]);

		errors += u_dut.u_props.violations;
		$display("%0d tests, %0d failed, %0d errors, %0d assertion failures", tests_run,
			tests_failed, errors, u_dut.u_props.violations);
		if (errors == 0 && tests_failed == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
